// File: files.f
dispatch_pkg.sv
dispatch_intf.sv
instr_decode.sv
reg_status_table.sv
dispatch_control.sv
fu_status_table.sv
dispatch_top.sv
tb_dispatch.sv

// File: tb_dispatch.sv
`timescale 1ns/100ps

module tb_dispatch;

    localparam int RAND_CYCLES = 3000;
    localparam int DRAIN_LIMIT = 8;

    logic                   CLK;
    logic                   nRST;
    logic [31:0]            instr;
    logic                   flush;
    logic                   wb_en;
    dispatch_pkg::reg_idx_t wb_rd;
    dispatch_pkg::tag_t     wb_tag;
    logic                   freeze;
    logic                   alu_busy;
    logic                   alu_ready;
    dispatch_pkg::reg_idx_t alu_rd;
    logic                   ldst_busy;
    logic                   ldst_ready;
    dispatch_pkg::reg_idx_t ldst_rd;

    // reference model with index 0 for the ALU and 1 for load/store
    logic                   rbusy [32];
    dispatch_pkg::tag_t     rtag  [32];
    logic                   fbusy [2];
    dispatch_pkg::reg_idx_t frd   [2];
    dispatch_pkg::reg_idx_t frs1  [2];
    dispatch_pkg::reg_idx_t frs2  [2];
    dispatch_pkg::tag_t     ft1   [2];
    dispatch_pkg::tag_t     ft2   [2];
    logic                   last_freeze;
    int                     errors;
    int                     checks;

    dispatch_top i_dispatch_top (
        .CLK (CLK), .nRST (nRST), .instr (instr), .flush (flush),
        .wb_en (wb_en), .wb_rd (wb_rd), .wb_tag (wb_tag), .freeze (freeze),
        .alu_busy (alu_busy), .alu_ready (alu_ready), .alu_rd (alu_rd),
        .ldst_busy (ldst_busy), .ldst_ready (ldst_ready), .ldst_rd (ldst_rd)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_value("alu_busy", alu_busy, fbusy[0]);
        check_value("alu_ready", alu_ready, fbusy[0] && ft1[0] == 0 && ft2[0] == 0);
        check_value("alu_rd", alu_rd, frd[0]);
        check_value("ldst_busy", ldst_busy, fbusy[1]);
        check_value("ldst_ready", ldst_ready, fbusy[1] && ft1[1] == 0 && ft2[1] == 0);
        check_value("ldst_rd", ldst_rd, frd[1]);
    endtask

    // compare, drive on the falling edge and advance the model by one cycle
    task automatic run_cycle(input logic [31:0] ins, input logic fl, input logic we,
                             input dispatch_pkg::reg_idx_t wrd, input dispatch_pkg::tag_t wtg);
        int                     u;
        logic                   rw;
        logic                   hz;
        dispatch_pkg::reg_idx_t rd;
        dispatch_pkg::reg_idx_t rs1;
        dispatch_pkg::reg_idx_t rs2;
        dispatch_pkg::tag_t     t1;
        dispatch_pkg::tag_t     t2;
        @(negedge CLK);
        compare_outputs();
        instr  = ins;
        flush  = fl;
        wb_en  = we;
        wb_rd  = wrd;
        wb_tag = wtg;
        #1;
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        u   = -1;
        case (ins[6:0])
            dispatch_pkg::OPC_OP:     u = 0;
            dispatch_pkg::OPC_OP_IMM: u = 0;
            dispatch_pkg::OPC_LOAD:   u = 1;
            dispatch_pkg::OPC_STORE:  u = 1;
            default:                  u = -1;
        endcase
        if (ins[6:0] == dispatch_pkg::OPC_OP_IMM || ins[6:0] == dispatch_pkg::OPC_LOAD)
            rs2 = '0;
        if (ins[6:0] == dispatch_pkg::OPC_STORE)
            rd = '0;
        rw = (u >= 0) && (rd != 0);
        hz = rw && rbusy[rd];
        if (u >= 0 && fbusy[u])
            hz = 1'b1;
        check_value("freeze", freeze, hz);
        last_freeze = hz;
        // source tags with same-cycle writeback bypass
        t1 = rbusy[rs1] ? rtag[rs1] : dispatch_pkg::TAG_NONE;
        if (we && wrd == rs1 && wtg == t1)
            t1 = dispatch_pkg::TAG_NONE;
        t2 = rbusy[rs2] ? rtag[rs2] : dispatch_pkg::TAG_NONE;
        if (we && wrd == rs2 && wtg == t2)
            t2 = dispatch_pkg::TAG_NONE;
        if (we) begin
            if (rtag[wrd] == wtg) begin
                rbusy[wrd] = 1'b0;
                rtag[wrd]  = dispatch_pkg::TAG_NONE;
            end
            for (int k = 0; k < 2; k++) begin
                if (ft1[k] == wtg && frs1[k] == wrd)
                    ft1[k] = dispatch_pkg::TAG_NONE;
                if (ft2[k] == wtg && frs2[k] == wrd)
                    ft2[k] = dispatch_pkg::TAG_NONE;
                if (wtg == dispatch_pkg::tag_t'(k + 1))
                    fbusy[k] = 1'b0;
            end
        end
        if (u >= 0 && !hz && !fl) begin
            if (rw) begin
                rbusy[rd] = 1'b1;
                rtag[rd]  = dispatch_pkg::tag_t'(u + 1);
            end
            fbusy[u] = 1'b1;
            frd[u]   = rd;
            frs1[u]  = rs1;
            frs2[u]  = rs2;
            ft1[u]   = t1;
            ft2[u]   = t2;
        end
    endtask

    function automatic logic [31:0] encode(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b010, rd, opc};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [6:0]  opc;
        w = $urandom;
        case ($urandom % 5)
            0:       opc = dispatch_pkg::OPC_OP;
            1:       opc = dispatch_pkg::OPC_OP_IMM;
            2:       opc = dispatch_pkg::OPC_LOAD;
            3:       opc = dispatch_pkg::OPC_STORE;
            default: opc = 7'b1100011;
        endcase
        // few registers so hazards come up often
        return {w[31:25], 5'($urandom % 8), 5'($urandom % 8), w[14:12],
                5'($urandom % 8), opc};
    endfunction

    initial begin
        int                     n;
        int                     k;
        logic [31:0]            cur;
        logic                   we;
        dispatch_pkg::reg_idx_t wrd;
        dispatch_pkg::tag_t     wtg;
        void'($urandom(32'hdf1));
        nRST = 1'b0;
        instr = '0;
        flush = 1'b0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_tag = dispatch_pkg::TAG_NONE;
        errors = 0;
        checks = 0;
        last_freeze = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rbusy[i] = 1'b0;
            rtag[i]  = dispatch_pkg::TAG_NONE;
        end
        for (int i = 0; i < 2; i++) begin
            fbusy[i] = 1'b0;
            frd[i]   = '0;
            frs1[i]  = '0;
            frs2[i]  = '0;
            ft1[i]   = dispatch_pkg::TAG_NONE;
            ft2[i]   = dispatch_pkg::TAG_NONE;
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // producer, dependent load, wakeup, bypass, hazards, flush
        run_cycle(32'h0, 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(encode(dispatch_pkg::OPC_OP, 5'd3, 5'd1, 5'd2), 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(encode(dispatch_pkg::OPC_LOAD, 5'd4, 5'd3, 5'd0), 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(32'h0, 1'b0, 1'b1, 5'd3, dispatch_pkg::TAG_ALU);
        run_cycle(encode(dispatch_pkg::OPC_OP, 5'd6, 5'd4, 5'd0), 1'b0, 1'b1, 5'd4,
                  dispatch_pkg::TAG_LDST);
        run_cycle(encode(dispatch_pkg::OPC_OP, 5'd7, 5'd1, 5'd1), 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(encode(dispatch_pkg::OPC_LOAD, 5'd6, 5'd1, 5'd0), 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(encode(dispatch_pkg::OPC_LOAD, 5'd0, 5'd6, 5'd0), 1'b0, 1'b0, 5'd0, 2'd0);
        run_cycle(32'h0, 1'b0, 1'b1, 5'd6, dispatch_pkg::TAG_ALU);
        run_cycle(32'h0, 1'b0, 1'b1, 5'd0, dispatch_pkg::TAG_LDST);
        run_cycle(encode(dispatch_pkg::OPC_OP, 5'd8, 5'd1, 5'd2), 1'b1, 1'b0, 5'd0, 2'd0);

        // random stream where a frozen instruction is held
        cur = random_instr();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            we  = 1'b0;
            wrd = 5'($urandom);
            wtg = dispatch_pkg::TAG_NONE;
            k   = $urandom % 2;
            if (!fbusy[k])
                k = 1 - k;
            if (fbusy[k] && ($urandom % 5) < 2) begin
                we  = 1'b1;
                wrd = frd[k];
                wtg = dispatch_pkg::tag_t'(k + 1);
            end
            run_cycle(cur, ($urandom % 16) == 0, we, wrd, wtg);
            if (!last_freeze)
                cur = random_instr();
        end

        // complete whatever is still in flight
        for (int u = 0; u < 2; u++) begin
            if (fbusy[u])
                run_cycle(32'h0, 1'b0, 1'b1, frd[u], dispatch_pkg::tag_t'(u + 1));
        end

        // wait for the DUT to show both units idle
        n = 0;
        while ((alu_busy || ldst_busy) && n < DRAIN_LIMIT) begin
            run_cycle(32'h0, 1'b0, 1'b0, 5'd0, 2'd0);
            n++;
        end
        if (alu_busy || ldst_busy) begin
            $display("timeout: units still busy after %0d idle cycles", DRAIN_LIMIT);
            errors++;
        end
        run_cycle(32'h0, 1'b0, 1'b0, 5'd0, 2'd0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: dispatch_top.sv
`timescale 1ns/100ps

module dispatch_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    input  logic                            flush,
    input  logic                            wb_en,
    input  dispatch_pkg::reg_idx_t          wb_rd,
    input  dispatch_pkg::tag_t              wb_tag,
    output logic                            freeze,
    output logic                            alu_busy,
    output logic                            alu_ready,
    output dispatch_pkg::reg_idx_t          alu_rd,
    output logic                            ldst_busy,
    output logic                            ldst_ready,
    output dispatch_pkg::reg_idx_t          ldst_rd
);

    decode_if dec_bus ();
    rst_if    rst_bus ();
    fust_if   fust_bus ();

    instr_decode i_instr_decode (
        .instr (instr),
        .dec   (dec_bus)
    );

    dispatch_control i_dispatch_control (
        .dec    (dec_bus),
        .rst    (rst_bus),
        .fust   (fust_bus),
        .flush  (flush),
        .freeze (freeze)
    );

    reg_status_table i_reg_status_table (
        .CLK    (CLK),
        .nRST   (nRST),
        .rst    (rst_bus),
        .wb_en  (wb_en),
        .wb_rd  (wb_rd),
        .wb_tag (wb_tag)
    );

    fu_status_table i_fu_status_table (
        .CLK        (CLK),
        .nRST       (nRST),
        .fust       (fust_bus),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_tag     (wb_tag),
        .alu_busy   (alu_busy),
        .alu_ready  (alu_ready),
        .alu_rd     (alu_rd),
        .ldst_busy  (ldst_busy),
        .ldst_ready (ldst_ready),
        .ldst_rd    (ldst_rd)
    );

endmodule

// File: fu_status_table.sv
`timescale 1ns/100ps

module fu_status_table (
    input  logic                   CLK,
    input  logic                   nRST,
    fust_if.tbl                    fust,
    input  logic                   wb_en,
    input  dispatch_pkg::reg_idx_t wb_rd,
    input  dispatch_pkg::tag_t     wb_tag,
    output logic                   alu_busy,
    output logic                   alu_ready,
    output dispatch_pkg::reg_idx_t alu_rd,
    output logic                   ldst_busy,
    output logic                   ldst_ready,
    output dispatch_pkg::reg_idx_t ldst_rd
);

    // slot 0 is the ALU, slot 1 the load/store unit
    logic                   busy_v  [dispatch_pkg::NUM_FU];
    logic                   ready_v [dispatch_pkg::NUM_FU];
    dispatch_pkg::reg_idx_t rd_v    [dispatch_pkg::NUM_FU];

    for (genvar u = 0; u < dispatch_pkg::NUM_FU; u++) begin : g_unit
        // unit code and tag are the slot index plus one
        localparam dispatch_pkg::tag_t OWN = dispatch_pkg::tag_t'(u + 1);

        dispatch_pkg::fust_entry_t ent;
        dispatch_pkg::fust_entry_t nxt;
        logic                      load;

        assign load = fust.en && (dispatch_pkg::tag_t'(fust.fu) == OWN);

        always_comb begin
            nxt = ent;
            if (wb_en) begin
                // wakeup on matching producer and register
                if (ent.t1 == wb_tag && ent.rs1 == wb_rd) begin
                    nxt.t1 = dispatch_pkg::TAG_NONE;
                end
                if (ent.t2 == wb_tag && ent.rs2 == wb_rd) begin
                    nxt.t2 = dispatch_pkg::TAG_NONE;
                end
                // this unit finished its own instruction
                if (wb_tag == OWN) begin
                    nxt.busy = 1'b0;
                end
            end
            if (load) begin
                nxt = fust.entry;
            end
        end

        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                ent <= '0;
            end else begin
                ent <= nxt;
            end
        end

        assign busy_v[u]  = ent.busy;
        assign ready_v[u] = ent.busy && ent.t1 == dispatch_pkg::TAG_NONE
                            && ent.t2 == dispatch_pkg::TAG_NONE;
        assign rd_v[u]    = ent.rd;
    end

    assign alu_busy   = busy_v[0];
    assign alu_ready  = ready_v[0];
    assign alu_rd     = rd_v[0];
    assign ldst_busy  = busy_v[1];
    assign ldst_ready = ready_v[1];
    assign ldst_rd    = rd_v[1];

    // busy back to dispatch for the structural check
    assign fust.alu_busy  = busy_v[0];
    assign fust.ldst_busy = busy_v[1];

endmodule

// File: dispatch_control.sv
`timescale 1ns/100ps

module dispatch_control (
    decode_if.dst  dec,
    rst_if.ctrl    rst,
    fust_if.ctrl   fust,
    input  logic   flush,
    output logic   freeze
);

    logic struct_hazard;
    logic waw_hazard;
    logic go;

    // structural hazard uses stored busy, a completing unit frees next cycle
    always_comb begin
        case (dec.fu)
            dispatch_pkg::FU_ALU:  struct_hazard = fust.alu_busy;
            dispatch_pkg::FU_LDST: struct_hazard = fust.ldst_busy;
            default:               struct_hazard = 1'b0;
        endcase
    end

    // destination still pending from an earlier producer
    assign waw_hazard = dec.reg_write && rst.rd_busy;

    assign freeze = struct_hazard || waw_hazard;

    // bubbles never dispatch
    assign go = (dec.fu != dispatch_pkg::FU_NONE) && !freeze && !flush;

    // register status table side
    assign rst.rs1_sel  = dec.rs1;
    assign rst.rs2_sel  = dec.rs2;
    assign rst.rd_sel   = dec.rd;
    assign rst.di_write = go && dec.reg_write;
    assign rst.di_sel   = dec.rd;
    assign rst.di_tag   = dispatch_pkg::tag_t'(dec.fu);

    // FU status table side
    assign fust.en = go;
    assign fust.fu = dec.fu;

    always_comb begin
        fust.entry        = '0;
        fust.entry.busy   = 1'b1;
        fust.entry.rd     = dec.rd;
        fust.entry.rs1    = dec.rs1;
        fust.entry.rs2    = dec.rs2;
        // tags already bypassed against this cycle's writeback
        fust.entry.t1     = rst.rs1_tag;
        fust.entry.t2     = rst.rs2_tag;
        fust.entry.i_flag = dec.i_flag;
        fust.entry.imm    = dec.imm;
        fust.entry.op     = dec.op;
    end

endmodule

// File: reg_status_table.sv
`timescale 1ns/100ps

module reg_status_table (
    input  logic                   CLK,
    input  logic                   nRST,
    rst_if.tbl                     rst,
    input  logic                   wb_en,
    input  dispatch_pkg::reg_idx_t wb_rd,
    input  dispatch_pkg::tag_t     wb_tag
);

    logic [dispatch_pkg::NUM_REGS-1:0] busy;
    dispatch_pkg::tag_t                tag [dispatch_pkg::NUM_REGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) begin
                tag[i] <= dispatch_pkg::TAG_NONE;
            end
        end else begin
            // completion only frees the register if it is still ours
            if (wb_en && tag[wb_rd] == wb_tag) begin
                busy[wb_rd] <= 1'b0;
                tag[wb_rd]  <= dispatch_pkg::TAG_NONE;
            end
            // new producer wins over a same-cycle completion, x0 never tracked
            if (rst.di_write && rst.di_sel != '0) begin
                busy[rst.di_sel] <= 1'b1;
                tag[rst.di_sel]  <= rst.di_tag;
            end
        end
    end

    // source lookups with writeback bypass
    always_comb begin
        rst.rs1_tag = busy[rst.rs1_sel] ? tag[rst.rs1_sel] : dispatch_pkg::TAG_NONE;
        if (wb_en && wb_rd == rst.rs1_sel && wb_tag == rst.rs1_tag) begin
            rst.rs1_tag = dispatch_pkg::TAG_NONE;
        end

        rst.rs2_tag = busy[rst.rs2_sel] ? tag[rst.rs2_sel] : dispatch_pkg::TAG_NONE;
        if (wb_en && wb_rd == rst.rs2_sel && wb_tag == rst.rs2_tag) begin
            rst.rs2_tag = dispatch_pkg::TAG_NONE;
        end
    end

    // stored state only, so WAW holds until the edge that clears it
    assign rst.rd_busy = busy[rst.rd_sel];

endmodule

// File: instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    decode_if.src                           dec
);

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic [dispatch_pkg::WORD_W-1:0] imm_i;
    logic [dispatch_pkg::WORD_W-1:0] imm_s;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // sign-extended immediates
    assign imm_i = {{(dispatch_pkg::WORD_W - 12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(dispatch_pkg::WORD_W - 12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        dec.fu     = dispatch_pkg::FU_NONE;
        dec.rd     = '0;
        dec.rs1    = '0;
        dec.rs2    = '0;
        dec.imm    = '0;
        dec.i_flag = 1'b0;
        dec.op     = '0;

        case (opcode)
            dispatch_pkg::OPC_OP: begin
                dec.fu  = dispatch_pkg::FU_ALU;
                dec.rd  = instr[11:7];
                dec.rs1 = instr[19:15];
                dec.rs2 = instr[24:20];
                dec.op  = {instr[30], funct3};
            end
            dispatch_pkg::OPC_OP_IMM: begin
                dec.fu     = dispatch_pkg::FU_ALU;
                dec.rd     = instr[11:7];
                dec.rs1    = instr[19:15];
                dec.imm    = imm_i;
                dec.i_flag = 1'b1;
                // bit 30 only means something for shifts (srai vs srli)
                dec.op     = {(funct3[1:0] == 2'b01) ? instr[30] : 1'b0, funct3};
            end
            dispatch_pkg::OPC_LOAD: begin
                dec.fu     = dispatch_pkg::FU_LDST;
                dec.rd     = instr[11:7];
                dec.rs1    = instr[19:15];
                dec.imm    = imm_i;
                dec.i_flag = 1'b1;
                dec.op     = {1'b0, funct3};
            end
            dispatch_pkg::OPC_STORE: begin
                // no destination, rs2 carries the store data
                dec.fu     = dispatch_pkg::FU_LDST;
                dec.rs1    = instr[19:15];
                dec.rs2    = instr[24:20];
                dec.imm    = imm_s;
                dec.i_flag = 1'b1;
                dec.op     = {1'b1, funct3};
            end
            default: begin
                // anything else goes down as a bubble
                dec.fu = dispatch_pkg::FU_NONE;
            end
        endcase

        // stores already have rd zeroed, so only alu ops and loads remain
        dec.reg_write = (dec.fu != dispatch_pkg::FU_NONE) && (dec.rd != '0);
    end

endmodule

// File: dispatch_intf.sv
`timescale 1ns/100ps

// decoded fields of the current instruction
interface decode_if;
    dispatch_pkg::fu_t               fu;
    dispatch_pkg::reg_idx_t          rd;
    dispatch_pkg::reg_idx_t          rs1;
    dispatch_pkg::reg_idx_t          rs2;
    logic                            reg_write;
    logic [dispatch_pkg::WORD_W-1:0] imm;
    logic                            i_flag;
    dispatch_pkg::alu_op_t           op;

    modport src (
        output fu, rd, rs1, rs2, reg_write, imm, i_flag, op
    );

    modport dst (
        input fu, rd, rs1, rs2, reg_write, imm, i_flag, op
    );
endinterface

// register status table, dispatch write plus three lookups
interface rst_if;
    logic                   di_write;
    dispatch_pkg::reg_idx_t di_sel;
    dispatch_pkg::tag_t     di_tag;
    dispatch_pkg::reg_idx_t rs1_sel;
    dispatch_pkg::reg_idx_t rs2_sel;
    dispatch_pkg::reg_idx_t rd_sel;
    dispatch_pkg::tag_t     rs1_tag;
    dispatch_pkg::tag_t     rs2_tag;
    logic                   rd_busy;

    modport ctrl (
        output di_write, di_sel, di_tag, rs1_sel, rs2_sel, rd_sel,
        input  rs1_tag, rs2_tag, rd_busy
    );

    modport tbl (
        input  di_write, di_sel, di_tag, rs1_sel, rs2_sel, rd_sel,
        output rs1_tag, rs2_tag, rd_busy
    );
endinterface

// function-unit status table load port
interface fust_if;
    logic                      en;
    dispatch_pkg::fu_t         fu;
    dispatch_pkg::fust_entry_t entry;
    logic                      alu_busy;
    logic                      ldst_busy;

    modport ctrl (
        output en, fu, entry,
        input  alu_busy, ldst_busy
    );

    modport tbl (
        input  en, fu, entry,
        output alu_busy, ldst_busy
    );
endinterface

// File: dispatch_pkg.sv
package dispatch_pkg;

    // ISA widths
    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;

    // execution units behind dispatch
    localparam int NUM_FU = 2;

    // opcodes handled by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef logic [REG_W-1:0] reg_idx_t;

    // a tag names the unit that will produce the value
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_NONE = 2'd0;
    localparam tag_t TAG_ALU  = 2'd1;
    localparam tag_t TAG_LDST = 2'd2;

    // codes line up with the tags above
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_LDST = 2'd2
    } fu_t;

    // {funct7[5], funct3}; for load/store {is_store, funct3}
    typedef logic [3:0] alu_op_t;

    typedef struct packed {
        logic              busy;
        reg_idx_t          rd;
        reg_idx_t          rs1;
        reg_idx_t          rs2;
        tag_t              t1;
        tag_t              t2;
        logic              i_flag;
        logic [WORD_W-1:0] imm;
        alu_op_t           op;
    } fust_entry_t;

endpackage
